/* hdl/cacheWay.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module cacheWay (
    input  logic  clk,
    input  logic  rst,
    wayPortIf.way port
);
    logic [`icacheSets-1:0] valid;
    icachePkg::indexT       readIndex;  // set that the rams are presenting
    icachePkg::tagT         storedTag;

    wayRam #(
        .payloadT (icachePkg::tagT)
    ) tagRam (
        .clk     (clk),
        .writeEn (port.fill),
        .addr    (port.index),
        .dataIn  (port.tag),
        .dataOut (storedTag)
    );

    wayRam #(
        .payloadT (icachePkg::lineT)
    ) lineRam (
        .clk     (clk),
        .writeEn (port.fill),
        .addr    (port.index),
        .dataIn  (port.fillLine),
        .dataOut (port.line)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (port.fill) begin
            valid[port.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        readIndex <= port.index;
    end

    // compare stage
    assign port.hit = valid[readIndex] && (storedTag == port.tag);

endmodule

/* hdl/fetchStage.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module fetchStage (
    input  logic            clk,
    input  logic            rst,
    input  logic            fetchValid,
    input  icachePkg::addrT fetchPc,
    input  logic            stall,
    wayPortIf.lookup        ways [`icacheWays],
    output logic            reqActive,
    output icachePkg::addrT reqPc
);
    icachePkg::indexT readIndex;
    icachePkg::tagT   reqTag;

    // fetch strobes are dropped while stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            reqActive <= 1'b0;
        end else if (!stall) begin
            reqActive <= fetchValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            reqPc <= fetchPc;
        end
    end

    // index goes straight to the rams so data is ready in the compare cycle
    assign readIndex = stall ? reqPc[`icacheOffsetBits +: `icacheIndexBits]
                             : fetchPc[`icacheOffsetBits +: `icacheIndexBits];
    assign reqTag    = reqPc[`icacheAddrBits-1 : `icacheOffsetBits+`icacheIndexBits];

    for (genvar g = 0; g < `icacheWays; g++) begin : gDrive
        assign ways[g].index = readIndex;
        assign ways[g].tag   = reqTag;
    end

endmodule

/* hdl/icachePkg.sv */
`include "icache_params.svh"

package icachePkg;

    typedef logic [`icacheAddrBits-1:0] addrT;

    typedef logic [`icacheIndexBits-1:0] indexT;

    // upper address bits above index and offset
    typedef logic [`icacheAddrBits-`icacheIndexBits-`icacheOffsetBits-1:0] tagT;

    typedef logic [`icacheLineBits-1:0] lineT;

    typedef logic [31:0] instT;

    typedef logic [$clog2(`icacheWays)-1:0] wayNumT;

    // tree pseudo-LRU, one bit per inner node
    typedef logic [`icacheWays-2:0] plruT;

endpackage

/* hdl/icacheTop.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module icacheTop (
    input  logic            clk,
    input  logic            rst,
    input  logic            fetchValid,
    input  icachePkg::addrT fetchPc,
    output logic            stall,
    output logic            inst0Valid,
    output logic            inst1Valid,
    output icachePkg::instT inst0,
    output icachePkg::instT inst1,
    output icachePkg::addrT outPc,
    output logic            memReqValid,
    output icachePkg::addrT memReqAddr,
    input  logic            memRespValid,
    input  icachePkg::lineT memRespLine
);
    logic            reqActive;
    icachePkg::addrT reqPc;

    wayPortIf ways [`icacheWays] ();

    fetchStage fetch (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .stall      (stall),
        .ways       (ways),
        .reqActive  (reqActive),
        .reqPc      (reqPc)
    );

    for (genvar g = 0; g < `icacheWays; g++) begin : gWays
        cacheWay way (
            .clk  (clk),
            .rst  (rst),
            .port (ways[g])
        );
    end

    missControl control (
        .clk          (clk),
        .rst          (rst),
        .ways         (ways),
        .reqActive    (reqActive),
        .reqPc        (reqPc),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .memRespValid (memRespValid),
        .memRespLine  (memRespLine),
        .stall        (stall),
        .inst0Valid   (inst0Valid),
        .inst0        (inst0),
        .inst1Valid   (inst1Valid),
        .inst1        (inst1),
        .outPc        (outPc)
    );

endmodule

/* hdl/icache_params.svh */
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// cache geometry
`define icacheWays       4
`define icacheSets       64

// fetch address split into tag, set index and byte offset
`define icacheAddrBits   32
`define icacheOffsetBits 4      // 16 bytes per line
`define icacheIndexBits  6

// one line holds four instruction words
`define icacheLineBits   128

`endif

/* hdl/missControl.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module missControl (
    input  logic            clk,
    input  logic            rst,
    wayPortIf.control       ways [`icacheWays],
    input  logic            reqActive,
    input  icachePkg::addrT reqPc,
    output logic            memReqValid,
    output icachePkg::addrT memReqAddr,
    input  logic            memRespValid,
    input  icachePkg::lineT memRespLine,
    output logic            stall,
    output logic            inst0Valid,
    output icachePkg::instT inst0,
    output logic            inst1Valid,
    output icachePkg::instT inst1,
    output icachePkg::addrT outPc
);
    typedef enum logic {sLookup, sRefill} stateT;

    stateT                                    state;
    logic                                     justFilled;  // held request already answered
    icachePkg::plruT                          plru [`icacheSets];
    logic [`icacheWays-1:0]                   hitVec;
    icachePkg::lineT                          wayLines [`icacheWays];
    icachePkg::indexT                         index;
    icachePkg::wayNumT                        hitWay;
    icachePkg::wayNumT                        victim;
    icachePkg::wayNumT                        usedWay;
    icachePkg::lineT                          outLine;
    icachePkg::instT [`icacheLineBits/32-1:0] lineWords;
    logic                                     lookupActive;
    logic                                     lookupHit;
    logic                                     lookupMiss;
    logic                                     refillDone;

    // bit 0 points away from the used half, bits 1/2 away inside it
    function automatic icachePkg::plruT touchPlru(
        icachePkg::plruT   old,
        icachePkg::wayNumT way
    );
        icachePkg::plruT upd;
        upd    = old;
        upd[0] = way[1];
        if (way[1]) begin
            upd[2] = way[0];
        end else begin
            upd[1] = way[0];
        end
        return upd;
    endfunction

    function automatic icachePkg::wayNumT pickVictim(icachePkg::plruT p);
        if (p[0]) begin
            return p[1] ? 2'd0 : 2'd1;
        end
        return p[2] ? 2'd2 : 2'd3;
    endfunction

    for (genvar g = 0; g < `icacheWays; g++) begin : gWay
        assign hitVec[g]        = ways[g].hit;
        assign wayLines[g]      = ways[g].line;
        assign ways[g].fill     = refillDone && (victim == g);
        assign ways[g].fillLine = memRespLine;
    end

    // lowest hitting way wins
    always_comb begin
        hitWay = '0;
        for (int w = `icacheWays - 1; w >= 0; w--) begin
            if (hitVec[w]) begin
                hitWay = icachePkg::wayNumT'(w);
            end
        end
    end

    assign index        = reqPc[`icacheOffsetBits +: `icacheIndexBits];
    assign victim       = pickVictim(plru[index]);
    assign lookupActive = (state == sLookup) && reqActive && !justFilled;
    assign lookupHit    = lookupActive && (|hitVec);
    assign lookupMiss   = lookupActive && !(|hitVec);
    assign refillDone   = (state == sRefill) && memRespValid;
    assign usedWay      = refillDone ? victim : hitWay;

    // miss data comes straight from the response
    assign outLine   = refillDone ? memRespLine : wayLines[hitWay];
    assign lineWords = outLine;

    assign stall       = lookupMiss || (state == sRefill);
    assign memReqValid = lookupMiss;
    assign memReqAddr  = {reqPc[`icacheAddrBits-1:`icacheOffsetBits], {`icacheOffsetBits{1'b0}}};
    assign inst0Valid  = (lookupHit || refillDone) && !reqPc[2];
    assign inst1Valid  = lookupHit || refillDone;
    assign inst0       = lineWords[{reqPc[3], 1'b0}];
    assign inst1       = lineWords[{reqPc[3], 1'b1}];
    assign outPc       = {reqPc[`icacheAddrBits-1:3], 1'b0, reqPc[1:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= sLookup;
            justFilled <= 1'b0;
        end else begin
            justFilled <= refillDone;
            case (state)
                sLookup: begin
                    if (lookupMiss) begin
                        state <= sRefill;
                    end
                end
                sRefill: begin
                    if (memRespValid) begin
                        state <= sLookup;
                    end
                end
                default: state <= sLookup;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `icacheSets; s++) begin
                plru[s] <= '0;
            end
        end else if (lookupHit || refillDone) begin
            plru[index] <= touchPlru(plru[index], usedWay);
        end
    end

endmodule

/* hdl/wayPortIf.sv */
`timescale 1ns/1ps

interface wayPortIf;
    icachePkg::indexT index;    // read/write set, one cycle ahead of compare
    icachePkg::tagT   tag;      // tag of the request under compare
    logic             hit;
    icachePkg::lineT  line;
    logic             fill;     // single-cycle write strobe
    icachePkg::lineT  fillLine;

    modport lookup (
        output index,
        output tag
    );

    modport way (
        input  index,
        input  tag,
        input  fill,
        input  fillLine,
        output hit,
        output line
    );

    modport control (
        input  hit,
        input  line,
        output fill,
        output fillLine
    );
endinterface

/* hdl/wayRam.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module wayRam #(
    parameter type payloadT = logic
) (
    input  logic                       clk,
    input  logic                       writeEn,
    input  logic [`icacheIndexBits-1:0] addr,
    input  payloadT                    dataIn,
    output payloadT                    dataOut
);
    payloadT mem [`icacheSets];

    // single port, read returns the old entry on a write
    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[addr] <= dataIn;
        end
        dataOut <= mem[addr];
    end

endmodule

/* sim.f */
+incdir+hdl
hdl/icachePkg.sv
hdl/wayPortIf.sv
hdl/wayRam.sv
hdl/cacheWay.sv
hdl/fetchStage.sv
hdl/missControl.sv
hdl/icacheTop.sv
testbench/icache_assertions.sv
testbench/icacheTb.sv

/* testbench/icacheTb.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module icacheTb;
    localparam int numFetches    = 400;
    localparam int timeoutCycles = numFetches * 8 + 100;

    logic            clk;
    logic            rst;
    logic            fetchValid;
    icachePkg::addrT fetchPc;
    logic            stall;
    logic            inst0Valid;
    logic            inst1Valid;
    icachePkg::instT inst0;
    icachePkg::instT inst1;
    icachePkg::addrT outPc;
    logic            memReqValid;
    icachePkg::addrT memReqAddr;
    logic            memRespValid;
    icachePkg::lineT memRespLine;

    integer          seed = 87948;
    int              cycles;
    int              acceptedCount;
    int              hits;
    int              misses;
    int              evictions;
    int              directedIdx;
    int              directedOrder [10] = '{0, 1, 2, 3, 4, 1, 2, 3, 4, 0};
    logic            lastAccepted;     // strobe of the current cycle was taken
    logic            pendingValid;     // accepted last cycle, compare due now
    logic            refilling;
    icachePkg::addrT pendingPc;
    icachePkg::addrT refillPc;

    icachePkg::tagT  modelTag   [`icacheSets][`icacheWays];
    logic            modelValid [`icacheSets][`icacheWays];
    icachePkg::plruT modelPlru  [`icacheSets];

    icacheTop dut (
        .clk          (clk),
        .rst          (rst),
        .fetchValid   (fetchValid),
        .fetchPc      (fetchPc),
        .stall        (stall),
        .inst0Valid   (inst0Valid),
        .inst1Valid   (inst1Valid),
        .inst0        (inst0),
        .inst1        (inst1),
        .outPc        (outPc),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .memRespValid (memRespValid),
        .memRespLine  (memRespLine)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stopWithFailure(string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic checkInst(string name, icachePkg::instT got, icachePkg::instT exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic checkAddr(string name, icachePkg::addrT got, icachePkg::addrT exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // memory contents, a fixed mix of line address and word number
    function icachePkg::instT memWord(icachePkg::addrT lineAddr, logic [1:0] word);
        return (lineAddr | {28'd0, word, 2'b00}) ^ {lineAddr[12:0], lineAddr[31:13]}
               ^ (32'h6b43_a9b5 * ({30'd0, word} + 32'd1));
    endfunction

    function icachePkg::lineT memLine(icachePkg::addrT lineAddr);
        icachePkg::lineT line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = memWord(lineAddr, w[1:0]);
        end
        return line;
    endfunction

    function icachePkg::addrT pickPc();
        int               k;
        icachePkg::indexT set;
        logic [1:0]       word;
        if (directedIdx < 10) begin
            k    = directedOrder[directedIdx];  // five tags into set 10, then revisit
            set  = 6'd10;
            word = directedIdx[1:0];
            directedIdx++;
        end else begin
            k    = $unsigned($random(seed)) % 6;
            set  = icachePkg::indexT'(($unsigned($random(seed)) % 4) * 16 + 5);
            word = 2'($unsigned($random(seed)) % 4);
        end
        return {icachePkg::tagT'(22'h0a5 + 22'h1013 * k), set, word, 2'b00};
    endfunction

    function icachePkg::plruT touchState(icachePkg::plruT s, icachePkg::wayNumT w);
        icachePkg::plruT n;
        n = s;
        if (w < 2) begin
            n[0] = 1'b0;
            n[1] = (w == 1);
        end else begin
            n[0] = 1'b1;
            n[2] = (w == 3);
        end
        return n;
    endfunction

    function icachePkg::wayNumT victimOf(icachePkg::plruT s);
        case ({s[0], s[1], s[2]})
            3'b110, 3'b111: return 2'd0;
            3'b100, 3'b101: return 2'd1;
            3'b001, 3'b011: return 2'd2;
            default:        return 2'd3;
        endcase
    endfunction

    task lookupModel(input icachePkg::addrT pc, output logic hit);
        hit = 1'b0;
        for (int w = 0; w < `icacheWays; w++) begin
            if (!hit && modelValid[pc[9:4]][w] && modelTag[pc[9:4]][w] == pc[31:10]) begin
                hit = 1'b1;
                modelPlru[pc[9:4]] = touchState(modelPlru[pc[9:4]], icachePkg::wayNumT'(w));
            end
        end
    endtask

    task fillModel(input icachePkg::addrT pc);
        icachePkg::wayNumT v;
        v = victimOf(modelPlru[pc[9:4]]);
        if (modelValid[pc[9:4]][v]) begin
            evictions++;
        end
        modelValid[pc[9:4]][v] = 1'b1;
        modelTag[pc[9:4]][v]   = pc[31:10];
        modelPlru[pc[9:4]]     = touchState(modelPlru[pc[9:4]], v);
    endtask

    task expectNoOutput();
        checkFlag("inst0Valid", inst0Valid, 1'b0);
        checkFlag("inst1Valid", inst1Valid, 1'b0);
    endtask

    task expectOutput(input icachePkg::addrT pc);
        icachePkg::addrT lineAddr;
        lineAddr = {pc[31:4], 4'b0000};
        checkFlag("inst0Valid", inst0Valid, !pc[2]);
        checkFlag("inst1Valid", inst1Valid, 1'b1);
        if (!pc[2]) begin
            checkInst("inst0", inst0, memWord(lineAddr, {pc[3], 1'b0}));
        end
        checkInst("inst1", inst1, memWord(lineAddr, {pc[3], 1'b1}));
        checkAddr("outPc", outPc, pc & ~32'h4);
    endtask

    // outputs sampled mid-cycle, model advanced once per cycle
    always @(negedge clk) begin : compareOutputs
        logic hit;
        if (!rst) begin
            if (dut.protocolChecks.failures != 0) begin
                stopWithFailure("a protocol assertion on the memory interface failed");
            end
            if (refilling) begin
                checkFlag("stall", stall, 1'b1);
                checkFlag("memReqValid", memReqValid, 1'b0);
                if (memRespValid) begin
                    expectOutput(refillPc);
                    fillModel(refillPc);
                    refilling = 1'b0;
                end else begin
                    expectNoOutput();
                end
            end else if (pendingValid) begin
                pendingValid = 1'b0;
                lookupModel(pendingPc, hit);
                checkFlag("stall", stall, !hit);
                checkFlag("memReqValid", memReqValid, !hit);
                if (hit) begin
                    hits++;
                    expectOutput(pendingPc);
                end else begin
                    misses++;
                    checkAddr("memReqAddr", memReqAddr, {pendingPc[31:4], 4'b0000});
                    expectNoOutput();
                    refilling = 1'b1;
                    refillPc  = pendingPc;
                end
            end else begin
                checkFlag("stall", stall, 1'b0);
                checkFlag("memReqValid", memReqValid, 1'b0);
                expectNoOutput();
            end
            lastAccepted = fetchValid && !stall;
            if (lastAccepted) begin
                pendingValid = 1'b1;
                pendingPc    = fetchPc;
                acceptedCount++;
            end
        end
    end

    // memory answers 1 to 4 cycles after the request
    initial begin : memoryModel
        int              delay;
        icachePkg::addrT lineAddr;
        memRespValid = 1'b0;
        memRespLine  = '0;
        forever begin
            @(negedge clk);
            if (memReqValid) begin
                lineAddr = memReqAddr;
                delay    = 1 + $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk);
                memRespValid <= 1'b1;
                memRespLine  <= memLine(lineAddr);
                @(posedge clk);
                memRespValid <= 1'b0;
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > timeoutCycles) begin
                stopWithFailure($sformatf("timeout: the run hung after %0d cycles, %0d fetches taken",
                                          cycles, acceptedCount));
            end
        end
    end

    initial begin
        rst           = 1'b1;
        fetchValid    = 1'b0;
        fetchPc       = '0;
        acceptedCount = 0;
        hits          = 0;
        misses        = 0;
        evictions     = 0;
        directedIdx   = 0;
        lastAccepted  = 1'b0;
        pendingValid  = 1'b0;
        refilling     = 1'b0;
        for (int s = 0; s < `icacheSets; s++) begin
            modelPlru[s] = '0;
            for (int w = 0; w < `icacheWays; w++) begin
                modelValid[s][w] = 1'b0;
                modelTag[s][w]   = '0;
            end
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // a refused strobe stays up with the same address
        do begin
            @(posedge clk);
            if (acceptedCount < numFetches && (!fetchValid || lastAccepted)) begin
                if (($random(seed) & 7) != 0) begin
                    fetchValid <= 1'b1;
                    fetchPc    <= pickPc();
                end else begin
                    fetchValid <= 1'b0;
                end
            end
        end while (acceptedCount < numFetches);
        fetchValid <= 1'b0;
        wait (!pendingValid && !refilling);
        repeat (3) @(posedge clk);
        if (hits == 0 || misses == 0 || evictions == 0) begin
            stopWithFailure($sformatf("coverage hole: %0d hits, %0d misses, %0d evictions",
                                      hits, misses, evictions));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* testbench/icache_assertions.sv */
`timescale 1ns/1ps

module icache_assertions (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic memReqValid,
    input logic memRespValid
);
    int   failures = 0;   // failed checks so far
    logic outstanding;    // line requested, no response yet

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (memReqValid) begin
            outstanding <= 1'b1;
        end else if (memRespValid) begin
            outstanding <= 1'b0;
        end
    end

    reqOnePulse: assert property (@(posedge clk) disable iff (rst)
        memReqValid |=> !memReqValid)
        else begin
            failures++;
            $error("memReqValid held for two cycles");
        end

    // stall covers the request and every cycle up to and including the response
    reqUnderStall: assert property (@(posedge clk) disable iff (rst)
        (memReqValid || outstanding) |-> stall)
        else begin
            failures++;
            $error("stall low during a memory request or before its response");
        end

    reqOneOutstanding: assert property (@(posedge clk) disable iff (rst)
        memReqValid |-> !outstanding)
        else begin
            failures++;
            $error("second memory request before the response");
        end

endmodule

bind icacheTop icache_assertions protocolChecks (
    .clk          (clk),
    .rst          (rst),
    .stall        (stall),
    .memReqValid  (memReqValid),
    .memRespValid (memRespValid)
);
